/* sim.f */
verilog/fpu_op_pkg.sv
verilog/fpu_data_pkg.sv
verilog/fpu_stage_if.sv
verilog/fpu_operand_fwd.sv
verilog/fpu_issue_stage.sv
verilog/fpu_compare.sv
verilog/fpu_permute_logic.sv
verilog/fpu_execute.sv
verilog/fpu_unit.sv
verif/fpu_unit_tb.sv

/* verif/fpu_unit_tb.sv */
`timescale 1ns/1ps

module fpu_unit_tb;
  import fpu_op_pkg::*;
  import fpu_data_pkg::*;

  localparam int CLK_PERIOD = 10;
  localparam int N_RAND     = 40;

  localparam fpu_data_t D_ONE   = 64'h3ff00000_00000000;
  localparam fpu_data_t D_TWO   = 64'h40000000_00000000;
  localparam fpu_data_t D_MONE  = 64'hbff00000_00000000;
  localparam fpu_data_t D_MTWO  = 64'hc0000000_00000000;
  localparam fpu_data_t D_NZERO = 64'h80000000_00000000;
  localparam fpu_data_t D_INF   = 64'h7ff00000_00000000;
  localparam fpu_data_t D_QNAN  = 64'h7ff80000_00000000;
  localparam fpu_data_t D_SNAN  = 64'h7ff00000_00000001;  // top fraction bit clear.
  localparam fpu_data_t BUS0    = 64'h11112222_33334444;
  localparam fpu_data_t BUS1    = 64'h55556666_77778888;
  localparam fpu_data_t BUS2    = 64'h9999aaaa_bbbbcccc;

  // flags are {un, gt, eq, lt}.
  localparam fpu_cond_t C_LT = 4'b0001;
  localparam fpu_cond_t C_EQ = 4'b0010;
  localparam fpu_cond_t C_GT = 4'b0100;
  localparam fpu_cond_t C_UN = 4'b1000;

  typedef struct packed {
    fpu_op_e         op;
    fpu_data_t       a;
    fpu_data_t       b;
    logic [2:0]      fa;
    logic [2:0]      fb;
    fpu_data_t [2:0] bus;
    logic            mask;
    fpu_data_t       exp_d;
    fpu_cond_t       exp_c;
    logic            exp_i;
  } vec_t;

  typedef struct packed {
    fpu_data_t data;
    fpu_cond_t cond;
    logic      inv;
    logic      exc;
  } exp_t;

  logic      clk = 1'b0;
  logic      rst;
  logic      issue_en;
  fpu_op_e   issue_op;
  fpu_data_t a_reg;
  fpu_data_t b_reg;
  logic [2:0] fwd_a;
  logic [2:0] fwd_b;
  fpu_data_t bus [3];
  logic      inv_mask;
  logic      res_valid;
  fpu_data_t res_data;
  fpu_cond_t res_cond;
  logic      res_invalid;
  logic      excpt;

  vec_t        tbl[$];
  string       tbl_name[$];
  exp_t        exp_q[$];
  string       name_q[$];
  bit          tbl_ready = 1'b0;
  logic        next_mask = 1'b0;
  logic [31:0] lcg_state = 32'h4e16;
  int          err_data  = 0;
  int          err_cond  = 0;
  int          err_flag  = 0;
  int          err_other = 0;

  fpu_unit #(.NUM_BUSES(3)) i_fpu_unit (
    .clk         (clk),
    .rst         (rst),
    .issue_en    (issue_en),
    .issue_op    (issue_op),
    .a_reg       (a_reg),
    .b_reg       (b_reg),
    .fwd_a       (fwd_a),
    .fwd_b       (fwd_b),
    .bus         (bus),
    .inv_mask    (inv_mask),
    .res_valid   (res_valid),
    .res_data    (res_data),
    .res_cond    (res_cond),
    .res_invalid (res_invalid),
    .excpt       (excpt)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic fpu_data_t rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi, lo};
  endfunction

  function automatic fpu_data_t pick_operand(logic [2:0] sel, fpu_data_t reg_val,
                                             fpu_data_t [2:0] buses);
    if (sel == 3'd0) return reg_val;
    return buses[sel - 3'd1];  // sel k is bus k-1.
  endfunction

  function automatic fpu_data_t model_logic(fpu_op_e op, fpu_data_t a, fpu_data_t b);
    case (op)
      op_and:  return a & b;
      op_or:   return a | b;
      op_xor:  return a ^ b;
      op_andn: return a & ~b;
      default: return a;  // mov.
    endcase
  endfunction

  function automatic vec_t random_vec();
    vec_t        v;
    logic [31:0] r;
    r = lcg_next();
    case (r[31:16] % 5)
      0:       v.op = op_and;
      1:       v.op = op_or;
      2:       v.op = op_xor;
      3:       v.op = op_andn;
      default: v.op = op_mov;
    endcase
    v.fa = 3'(r[15:14]);
    v.fb = 3'(r[13:12]);
    v.mask = r[0];
    v.a = rand_word();
    v.b = rand_word();
    for (int k = 0; k < 3; k++) begin
      v.bus[k] = rand_word();
    end
    v.exp_d = model_logic(v.op, pick_operand(v.fa, v.a, v.bus), pick_operand(v.fb, v.b, v.bus));
    v.exp_c = '0;
    v.exp_i = 1'b0;
    return v;
  endfunction

  task automatic add_vec(string name, fpu_op_e op, fpu_data_t a, fpu_data_t b,
                         logic [2:0] fa, logic [2:0] fb, logic mask,
                         fpu_data_t exp_d, fpu_cond_t exp_c, logic exp_i);
    vec_t v;
    v = '{op: op, a: a, b: b, fa: fa, fb: fb, bus: {BUS2, BUS1, BUS0}, mask: mask,
          exp_d: exp_d, exp_c: exp_c, exp_i: exp_i};
    tbl.push_back(v);
    tbl_name.push_back(name);
  endtask

  task automatic apply(vec_t v, string name);
    exp_t e;
    issue_en = 1'b1;
    issue_op = v.op;
    a_reg    = v.a;
    b_reg    = v.b;
    fwd_a    = v.fa;
    fwd_b    = v.fb;
    for (int k = 0; k < 3; k++) begin
      bus[k] = v.bus[k];
    end
    e.data = v.exp_d;
    e.cond = v.exp_c;
    e.inv  = v.exp_i;
    e.exc  = v.exp_i && !v.mask;  // masked invalid never traps.
    exp_q.push_back(e);
    name_q.push_back(name);
  endtask

  task automatic idle(int n);
    repeat (n) begin
      @(negedge clk);
      issue_en  = 1'b0;
      inv_mask  = next_mask;
      next_mask = 1'b0;
    end
  endtask

  task automatic check_data(string name, fpu_data_t exp, fpu_data_t act);
    if (act !== exp) begin
      err_data++;
      $display("Error %s: data expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic check_cond(string name, fpu_cond_t exp, fpu_cond_t act);
    if (act !== exp) begin
      err_cond++;
      $display("Error %s: cond (un gt eq lt) expected %b, got %b", name, exp, act);
    end
  endtask

  task automatic check_bit(string name, string what, logic exp, logic act);
    if (act !== exp) begin
      err_flag++;
      $display("Error %s: %s expected %b, got %b", name, what, exp, act);
    end
  endtask

  task automatic print_counts();
    $display("errors: data %0d, cond %0d, flags %0d, other %0d",
             err_data, err_cond, err_flag, err_other);
  endtask

  always @(negedge clk) begin : check_results
    exp_t  e;
    string n;
    if (res_valid) begin
      if (exp_q.size() == 0) begin
        err_other++;
        $display("a result came out with no operation outstanding");
      end else begin
        e = exp_q.pop_front();
        n = name_q.pop_front();
        check_data(n, e.data, res_data);
        check_cond(n, e.cond, res_cond);
        check_bit(n, "invalid", e.inv, res_invalid);
        check_bit(n, "excpt", e.exc, excpt);
      end
    end else if (excpt) begin
      err_other++;
      $display("excpt is high while no result is valid");
    end
  end

  initial begin : watchdog
    wait (tbl_ready);
    #((tbl.size() + N_RAND + 20) * CLK_PERIOD);
    $display("timeout with %0d results still outstanding", exp_q.size());
    print_counts();
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    vec_t rand_v;
    rst      = 1'b1;
    issue_en = 1'b0;
    issue_op = op_and;
    a_reg    = '0;
    b_reg    = '0;
    fwd_a    = '0;
    fwd_b    = '0;
    inv_mask = 1'b0;
    for (int k = 0; k < 3; k++) begin
      bus[k] = '0;
    end

    add_vec("and", op_and, 64'hf0f0f0f0_0f0f0f0f, 64'hff00ff00_ff00ff00, 0, 0, 0,
            64'hf000f000_0f000f00, '0, 0);
    add_vec("or", op_or, 64'hf0f0f0f0_0f0f0f0f, 64'hff00ff00_ff00ff00, 0, 0, 0,
            64'hfff0fff0_ff0fff0f, '0, 0);
    add_vec("xor", op_xor, 64'hf0f0f0f0_0f0f0f0f, 64'hff00ff00_ff00ff00, 0, 0, 0,
            64'h0ff00ff0_f00ff00f, '0, 0);
    add_vec("andn", op_andn, 64'hf0f0f0f0_0f0f0f0f, 64'hff00ff00_ff00ff00, 0, 0, 0,
            64'h00f000f0_000f000f, '0, 0);
    add_vec("mov", op_mov, 64'h01234567_89abcdef, '1, 0, 0, 0, 64'h01234567_89abcdef, '0, 0);
    add_vec("swp_s", op_swp_s, 64'h01234567_89abcdef, '0, 0, 0, 0,
            64'h89abcdef_01234567, '0, 0);
    add_vec("dup_lo", op_dup_lo, 64'h01234567_89abcdef, '0, 0, 0, 0,
            64'h89abcdef_89abcdef, '0, 0);
    add_vec("dup_hi", op_dup_hi, 64'h01234567_89abcdef, '0, 0, 0, 0,
            64'h01234567_01234567, '0, 0);
    add_vec("pack_lo", op_pack_lo, 64'h01234567_89abcdef, 64'hdeadbeef_cafef00d, 0, 0, 0,
            64'hcafef00d_89abcdef, '0, 0);
    // forwarding, back to back.
    add_vec("fwd_a_bus0", op_mov, D_ONE, '0, 1, 0, 0, BUS0, '0, 0);
    add_vec("fwd_a_bus2", op_mov, D_ONE, '0, 3, 0, 0, BUS2, '0, 0);
    add_vec("fwd_b_bus1", op_xor, 64'hffffffff_00000000, '0, 0, 2, 0,
            64'haaaa9999_77778888, '0, 0);
    add_vec("fwd_both", op_and, '1, '1, 3, 2, 0, 64'h11112222_33338888, '0, 0);
    add_vec("fwd_pack_b", op_pack_lo, 64'haaaaaaaa_12345678, '0, 0, 1, 0,
            64'h33334444_12345678, '0, 0);
    // scalar double compares.
    add_vec("cmp_d_lt", op_cmp_d, D_ONE, D_TWO, 0, 0, 0, '0, C_LT, 0);
    add_vec("cmp_d_gt", op_cmp_d, D_TWO, D_MONE, 0, 0, 0, '0, C_GT, 0);
    add_vec("cmp_d_zero", op_cmp_d, '0, D_NZERO, 0, 0, 0, '0, C_EQ, 0);
    add_vec("cmp_d_neg", op_cmp_d, D_MTWO, D_MONE, 0, 0, 0, '0, C_LT, 0);
    add_vec("cmp_d_inf", op_cmp_d, D_INF, D_TWO, 0, 0, 0, '0, C_GT, 0);
    add_vec("cmp_d_qnan", op_cmp_d, D_QNAN, D_ONE, 0, 0, 0, '0, C_UN, 1);
    add_vec("cmp_d_qnan_masked", op_cmp_d, D_ONE, D_QNAN, 0, 0, 1, '0, C_UN, 1);
    add_vec("cmp_du_qnan", op_cmp_du, D_QNAN, D_ONE, 0, 0, 0, '0, C_UN, 0);
    add_vec("cmp_du_snan", op_cmp_du, D_ONE, D_SNAN, 0, 0, 0, '0, C_UN, 1);
    add_vec("cmp_du_gt", op_cmp_du, D_TWO, D_ONE, 0, 0, 0, '0, C_GT, 0);
    // packed-single less-than.
    add_vec("pcmplt_mix", op_pcmplt_s, 64'h40000000_3f800000, 64'h3f800000_40000000, 0, 0, 0,
            64'h00000000_ffffffff, '0, 0);
    add_vec("pcmplt_neg", op_pcmplt_s, 64'hc0400000_bf800000, 64'hbf800000_c0400000, 0, 0, 0,
            64'hffffffff_00000000, '0, 0);
    add_vec("pcmplt_nan", op_pcmplt_s, 64'h7fc00000_3f800000, 64'h40000000_40000000, 0, 0, 0,
            64'h00000000_ffffffff, '0, 1);
    add_vec("pcmplt_nan_masked", op_pcmplt_s, 64'h3f800000_3f800000, 64'h40000000_7f800001,
            0, 0, 1, 64'hffffffff_00000000, '0, 1);
    tbl_ready = 1'b1;

    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_bit("reset", "res_valid", 1'b0, res_valid);
    check_bit("reset", "excpt", 1'b0, excpt);
    check_bit("reset", "invalid", 1'b0, res_invalid);
    check_data("reset", '0, res_data);
    check_cond("reset", '0, res_cond);
    idle(1);

    for (int i = 0; i < tbl.size(); i++) begin
      @(negedge clk);
      inv_mask  = next_mask;  // mask belongs to the op now in execute.
      apply(tbl[i], tbl_name[i]);
      next_mask = tbl[i].mask;
    end
    idle(3);

    for (int i = 0; i < N_RAND; i++) begin
      rand_v = random_vec();
      @(negedge clk);
      inv_mask = next_mask;
      apply(rand_v, $sformatf("random_%0d", i));
      next_mask = rand_v.mask;
    end
    idle(1);

    wait (exp_q.size() == 0);
    idle(3);
    print_counts();
    if (err_data + err_cond + err_flag + err_other == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* verilog/fpu_compare.sv */
`timescale 1ns/1ps

module fpu_compare (
  input  fpu_data_pkg::fpu_data_t a,
  input  fpu_data_pkg::fpu_data_t b,
  input  logic                    quiet,
  input  logic                    pkd,
  output fpu_data_pkg::fpu_cond_t cond,
  output fpu_data_pkg::fpu_data_t mask,
  output logic                    invalid
);
  import fpu_data_pkg::*;

  logic [31:0] a_lo;
  logic [31:0] a_hi;
  logic [31:0] b_lo;
  logic [31:0] b_hi;
  logic        un_d;
  logic        nan_lo;
  logic        nan_hi;
  logic [2:0]  ord_d;
  logic [2:0]  ord_lo;
  logic [2:0]  ord_hi;

  // sign-magnitude order of two non-nan values, as {gt, eq, lt}.
  function automatic logic [2:0] order(logic sa, logic sb, logic [62:0] ma,
                                       logic [62:0] mb);
    logic less;
    if (ma == '0 && mb == '0) return 3'b010;  // +0 == -0.
    if (sa != sb) return sa ? 3'b001 : 3'b100;
    if (ma == mb) return 3'b010;
    less = sa ? (ma > mb) : (ma < mb);
    return less ? 3'b001 : 3'b100;
  endfunction

  assign a_lo = lo_s(a);
  assign a_hi = hi_s(a);
  assign b_lo = lo_s(b);
  assign b_hi = hi_s(b);

  assign un_d   = is_nan_d(a) || is_nan_d(b);
  assign nan_lo = is_nan_s(a_lo) || is_nan_s(b_lo);
  assign nan_hi = is_nan_s(a_hi) || is_nan_s(b_hi);

  assign ord_d  = order(a[63], b[63], a[62:0], b[62:0]);
  assign ord_lo = order(a_lo[31], b_lo[31], {32'b0, a_lo[30:0]}, {32'b0, b_lo[30:0]});
  assign ord_hi = order(a_hi[31], b_hi[31], {32'b0, a_hi[30:0]}, {32'b0, b_hi[30:0]});

  always_comb begin
    if (pkd) begin
      cond    = '0;
      mask    = pack_s({32{ord_hi[0] && !nan_hi}}, {32{ord_lo[0] && !nan_lo}});
      invalid = nan_lo || nan_hi;
    end else begin
      cond.un = un_d;
      {cond.gt, cond.eq, cond.lt} = un_d ? 3'b000 : ord_d;
      mask    = '0;
      // quiet form only traps on signaling nans.
      invalid = quiet ? (is_snan_d(a) || is_snan_d(b)) : un_d;
    end
  end

endmodule

/* verilog/fpu_data_pkg.sv */
package fpu_data_pkg;

  // low single in [31:0], high single in [63:32].
  typedef logic [63:0] fpu_data_t;

  typedef struct packed {
    logic un;
    logic gt;
    logic eq;
    logic lt;
  } fpu_cond_t;

  function automatic logic [31:0] lo_s(fpu_data_t x);
    return x[31:0];
  endfunction

  function automatic logic [31:0] hi_s(fpu_data_t x);
    return x[63:32];
  endfunction

  function automatic fpu_data_t pack_s(logic [31:0] hi, logic [31:0] lo);
    return {hi, lo};
  endfunction

  function automatic logic is_nan_d(fpu_data_t x);
    return (&x[62:52]) && (|x[51:0]);
  endfunction

  // quiet bit is the top fraction bit.
  function automatic logic is_snan_d(fpu_data_t x);
    return is_nan_d(x) && !x[51];
  endfunction

  function automatic logic is_nan_s(logic [31:0] x);
    return (&x[30:23]) && (|x[22:0]);
  endfunction

endpackage

/* verilog/fpu_execute.sv */
`timescale 1ns/1ps

module fpu_execute (
  input  logic                    clk,
  input  logic                    rst,
  fpu_stage_if.exec               stage,
  input  logic                    inv_mask,
  output logic                    res_valid,
  output fpu_data_pkg::fpu_data_t res_data,
  output fpu_data_pkg::fpu_cond_t res_cond,
  output logic                    res_invalid,
  output logic                    excpt
);
  import fpu_op_pkg::*;
  import fpu_data_pkg::*;

  fpu_cond_t cmp_cond;
  fpu_data_t cmp_mask;
  logic      cmp_invalid;
  fpu_data_t pl_res;
  fpu_data_t sel_data;
  fpu_cond_t sel_cond;
  logic      sel_invalid;

  fpu_compare i_compare (
    .a       (stage.a),
    .b       (stage.b),
    .quiet   (stage.ctrl.quiet),
    .pkd     (stage.ctrl.pkd),
    .cond    (cmp_cond),
    .mask    (cmp_mask),
    .invalid (cmp_invalid)
  );

  fpu_permute_logic i_permute_logic (
    .a    (stage.a),
    .b    (stage.b),
    .unit (stage.ctrl.unit),
    .sub  (stage.ctrl.sub),
    .res  (pl_res)
  );

  always_comb begin
    if (stage.ctrl.unit == unit_cmp) begin
      sel_data    = cmp_mask;  // zero for scalar compares.
      sel_cond    = cmp_cond;
      sel_invalid = cmp_invalid;
    end else begin
      sel_data    = pl_res;
      sel_cond    = '0;
      sel_invalid = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid   <= 1'b0;
      res_data    <= '0;
      res_cond    <= '0;
      res_invalid <= 1'b0;
      excpt       <= 1'b0;
    end else begin
      res_valid <= stage.valid;
      excpt     <= stage.valid && sel_invalid && !inv_mask;
      if (stage.valid) begin
        res_data    <= sel_data;
        res_cond    <= sel_cond;
        res_invalid <= sel_invalid;
      end
    end
  end

  // unordered excludes every ordered outcome.
  a_cond_exclusive: assert property (
    @(posedge clk) disable iff (rst)
    stage.valid |-> !(cmp_cond.un && (cmp_cond.lt || cmp_cond.eq || cmp_cond.gt))
  ) else $error("compare flags un together with an ordered flag");

  a_excpt_valid: assert property (
    @(posedge clk) disable iff (rst)
    excpt |-> res_valid
  ) else $error("excpt without a valid result");

endmodule

/* verilog/fpu_issue_stage.sv */
`timescale 1ns/1ps

module fpu_issue_stage #(
  parameter int NUM_BUSES = 3
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    issue_en,
  input  fpu_op_pkg::fpu_op_e     issue_op,
  input  fpu_data_pkg::fpu_data_t a_reg,
  input  fpu_data_pkg::fpu_data_t b_reg,
  input  logic [2:0]              fwd_a,
  input  logic [2:0]              fwd_b,
  input  fpu_data_pkg::fpu_data_t bus [NUM_BUSES],
  fpu_stage_if.issue              stage
);
  import fpu_op_pkg::*;
  import fpu_data_pkg::*;

  fpu_data_t a_fwd;
  fpu_data_t b_fwd;
  fpu_ctrl_t dec_ctrl;
  logic      dec_legal;
  logic      zero_b;

  fpu_operand_fwd #(.NUM_BUSES(NUM_BUSES)) i_fwd_a (
    .clk     (clk),
    .rst     (rst),
    .reg_val (a_reg),
    .fwd_sel (fwd_a),
    .bus     (bus),
    .en      (issue_en),
    .opnd    (a_fwd)
  );

  fpu_operand_fwd #(.NUM_BUSES(NUM_BUSES)) i_fwd_b (
    .clk     (clk),
    .rst     (rst),
    .reg_val (b_reg),
    .fwd_sel (fwd_b),
    .bus     (bus),
    .en      (issue_en),
    .opnd    (b_fwd)
  );

  always_comb begin
    dec_ctrl  = '{unit: unit_logic, sub: lg_and, quiet: 1'b0, pkd: 1'b0};
    dec_legal = 1'b1;
    zero_b    = 1'b0;
    case (issue_op)
      op_and:  dec_ctrl.sub = lg_and;
      op_or:   dec_ctrl.sub = lg_or;
      op_xor:  dec_ctrl.sub = lg_xor;
      op_andn: dec_ctrl.sub = lg_andn;
      op_mov: begin
        dec_ctrl.sub = lg_or;  // a or zero.
        zero_b       = 1'b1;
      end
      op_swp_s: begin
        dec_ctrl.unit = unit_perm;
        dec_ctrl.sub  = pm_swap;
      end
      op_dup_lo: begin
        dec_ctrl.unit = unit_perm;
        dec_ctrl.sub  = pm_dup_lo;
      end
      op_dup_hi: begin
        dec_ctrl.unit = unit_perm;
        dec_ctrl.sub  = pm_dup_hi;
      end
      op_pack_lo: begin
        dec_ctrl.unit = unit_perm;
        dec_ctrl.sub  = pm_pack_lo;
      end
      op_cmp_d: dec_ctrl.unit = unit_cmp;
      op_cmp_du: begin
        dec_ctrl.unit  = unit_cmp;
        dec_ctrl.quiet = 1'b1;
      end
      op_pcmplt_s: begin
        dec_ctrl.unit = unit_cmp;
        dec_ctrl.pkd  = 1'b1;
      end
      default: dec_legal = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      stage.valid <= 1'b0;
      stage.ctrl  <= '{unit: unit_logic, sub: lg_and, quiet: 1'b0, pkd: 1'b0};
    end else begin
      stage.valid <= issue_en && dec_legal;  // illegal op is dropped.
      if (issue_en) begin
        stage.ctrl <= dec_ctrl;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue_en) begin
      stage.a <= a_fwd;
      stage.b <= zero_b ? '0 : b_fwd;
    end
  end

  a_legal_op: assert property (
    @(posedge clk) disable iff (rst)
    issue_en |-> dec_legal
  ) else $error("illegal opcode %0d issued", issue_op);

endmodule

/* verilog/fpu_op_pkg.sv */
package fpu_op_pkg;

  // issue opcodes. codes 12 to 31 are illegal.
  typedef enum logic [4:0] {
    op_and      = 5'd0,
    op_or       = 5'd1,
    op_xor      = 5'd2,
    op_andn     = 5'd3,  // a and not b.
    op_mov      = 5'd4,
    op_swp_s    = 5'd5,
    op_dup_lo   = 5'd6,
    op_dup_hi   = 5'd7,
    op_pack_lo  = 5'd8,
    op_cmp_d    = 5'd9,
    op_cmp_du   = 5'd10,
    op_pcmplt_s = 5'd11
  } fpu_op_e;

  // datapath select.
  typedef enum logic [1:0] {
    unit_logic = 2'd0,
    unit_perm  = 2'd1,
    unit_cmp   = 2'd2
  } fpu_unit_e;

  // sub select in the logic datapath.
  localparam logic [1:0] lg_and  = 2'd0;
  localparam logic [1:0] lg_or   = 2'd1;
  localparam logic [1:0] lg_xor  = 2'd2;
  localparam logic [1:0] lg_andn = 2'd3;

  // sub select in the permute datapath.
  localparam logic [1:0] pm_swap    = 2'd0;
  localparam logic [1:0] pm_dup_lo  = 2'd1;
  localparam logic [1:0] pm_dup_hi  = 2'd2;
  localparam logic [1:0] pm_pack_lo = 2'd3;

  typedef struct packed {
    fpu_unit_e  unit;
    logic [1:0] sub;
    logic       quiet;  // compare raises invalid on snan only.
    logic       pkd;    // packed-single compare.
  } fpu_ctrl_t;

endpackage

/* verilog/fpu_operand_fwd.sv */
`timescale 1ns/1ps

module fpu_operand_fwd #(
  parameter int NUM_BUSES = 3
) (
  input  logic                    clk,
  input  logic                    rst,
  input  fpu_data_pkg::fpu_data_t reg_val,
  input  logic [2:0]              fwd_sel,
  input  fpu_data_pkg::fpu_data_t bus [NUM_BUSES],
  input  logic                    en,
  output fpu_data_pkg::fpu_data_t opnd
);

  // sel 0 is the register file, sel k is bus k-1.
  always_comb begin
    opnd = reg_val;
    for (int k = 0; k < NUM_BUSES; k++) begin
      if (fwd_sel == 3'(k + 1)) begin
        opnd = bus[k];
      end
    end
  end

  // a select past the last bus would silently fall back to reg_val.
  a_fwd_sel_range: assert property (
    @(posedge clk) disable iff (rst)
    en |-> (fwd_sel <= 3'(NUM_BUSES))
  ) else $error("fwd_sel %0d out of range", fwd_sel);

endmodule

/* verilog/fpu_permute_logic.sv */
`timescale 1ns/1ps

module fpu_permute_logic (
  input  fpu_data_pkg::fpu_data_t a,
  input  fpu_data_pkg::fpu_data_t b,
  input  fpu_op_pkg::fpu_unit_e   unit,
  input  logic [1:0]              sub,
  output fpu_data_pkg::fpu_data_t res
);
  import fpu_op_pkg::*;
  import fpu_data_pkg::*;

  fpu_data_t logic_res;
  fpu_data_t perm_res;

  always_comb begin
    case (sub)
      lg_and:  logic_res = a & b;
      lg_or:   logic_res = a | b;
      lg_xor:  logic_res = a ^ b;
      default: logic_res = a & ~b;  // andn.
    endcase
  end

  always_comb begin
    case (sub)
      pm_swap:   perm_res = pack_s(lo_s(a), hi_s(a));
      pm_dup_lo: perm_res = pack_s(lo_s(a), lo_s(a));
      pm_dup_hi: perm_res = pack_s(hi_s(a), hi_s(a));
      default:   perm_res = pack_s(lo_s(b), lo_s(a));  // pack_lo.
    endcase
  end

  assign res = (unit == unit_perm) ? perm_res : logic_res;

endmodule

/* verilog/fpu_stage_if.sv */
`timescale 1ns/1ps

// one decoded operation between the issue and execute stages.
interface fpu_stage_if;
  import fpu_op_pkg::*;
  import fpu_data_pkg::*;

  logic      valid;
  fpu_ctrl_t ctrl;
  fpu_data_t a;
  fpu_data_t b;

  modport issue (
    output valid,
    output ctrl,
    output a,
    output b
  );

  modport exec (
    input valid,
    input ctrl,
    input a,
    input b
  );

endinterface

/* verilog/fpu_unit.sv */
`timescale 1ns/1ps

module fpu_unit #(
  parameter int NUM_BUSES = 3
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    issue_en,
  input  fpu_op_pkg::fpu_op_e     issue_op,
  input  fpu_data_pkg::fpu_data_t a_reg,
  input  fpu_data_pkg::fpu_data_t b_reg,
  input  logic [2:0]              fwd_a,
  input  logic [2:0]              fwd_b,
  input  fpu_data_pkg::fpu_data_t bus [NUM_BUSES],
  input  logic                    inv_mask,
  output logic                    res_valid,
  output fpu_data_pkg::fpu_data_t res_data,
  output fpu_data_pkg::fpu_cond_t res_cond,
  output logic                    res_invalid,
  output logic                    excpt
);

  fpu_stage_if stage ();

  fpu_issue_stage #(.NUM_BUSES(NUM_BUSES)) i_issue_stage (
    .clk      (clk),
    .rst      (rst),
    .issue_en (issue_en),
    .issue_op (issue_op),
    .a_reg    (a_reg),
    .b_reg    (b_reg),
    .fwd_a    (fwd_a),
    .fwd_b    (fwd_b),
    .bus      (bus),
    .stage    (stage.issue)
  );

  fpu_execute i_execute (
    .clk         (clk),
    .rst         (rst),
    .stage       (stage.exec),
    .inv_mask    (inv_mask),
    .res_valid   (res_valid),
    .res_data    (res_data),
    .res_cond    (res_cond),
    .res_invalid (res_invalid),
    .excpt       (excpt)
  );

endmodule
